//--- bench/fetch_frontend_tb.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_frontend_tb;

  import fetch_types_pkg::*;
  import redirect_pkg::*;

  localparam addr_t fault_addr = 32'h0000_1010;

  logic                           clk_i = 1'b0;
  logic                           rst_ni;
  addr_t [`FETCH_NUM_THREADS-1:0] boot_addr_i;
  logic                           flush_i;
  logic                           halt_i;
  branch_resolve_t                branch_i;
  eret_req_t                      eret_i;
  trap_req_t                      trap_i;
  commit_req_t                    commit_i;
  icache_req_t                    icache_req_o;
  icache_rsp_t                    icache_rsp_i = '0;
  fetch_entry_t                   fetch_entry_o;
  logic                           fetch_entry_valid_o;
  logic                           fetch_entry_ready_i;

  // reference state kept by the compare process
  addr_t        model_pc [`FETCH_NUM_THREADS];
  fetch_entry_t exp_q [$];
  fetch_entry_t got_q [$];
  icache_req_t  pend_q [$];
  int           seed = 32'h5c67;
  int           rsp_delay = -1;
  int           mismatches = 0;
  int           failures = 0;
  logic         rand_ready = 1'b1;
  logic         rr_check = 1'b0;
  logic         rr_started = 1'b0;
  tid_t         last_tid = '0;
  logic         fault_seen = 1'b0;

  always #5 clk_i = ~clk_i;

  fetch_frontend dut0 (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .boot_addr_i         (boot_addr_i),
    .flush_i             (flush_i),
    .halt_i              (halt_i),
    .branch_i            (branch_i),
    .eret_i              (eret_i),
    .trap_i              (trap_i),
    .commit_i            (commit_i),
    .icache_req_o        (icache_req_o),
    .icache_rsp_i        (icache_rsp_i),
    .fetch_entry_o       (fetch_entry_o),
    .fetch_entry_valid_o (fetch_entry_valid_o),
    .fetch_entry_ready_i (fetch_entry_ready_i)
  );

  // ----------------------------------------
  // reference rules
  // ----------------------------------------
  function automatic instr_t instr_of(addr_t vaddr);
    return {vaddr[15:0], vaddr[31:16]} ^ (vaddr << 7) ^ 32'h0000_0013;
  endfunction

  // mispredict, then eret, then trap, then commit, then sequential advance
  function automatic pc_write_t next_pc(branch_resolve_t b, eret_req_t e, trap_req_t t,
                                        commit_req_t c, logic halt, logic acc,
                                        tid_t tid, addr_t pc);
    pc_write_t w;
    w = '0;
    if (b.valid && b.mispredict) begin
      w = pc_write_t'{en: 1'b1, tid: b.tid, value: b.target};
    end else if (e.valid) begin
      w = pc_write_t'{en: 1'b1, tid: e.tid, value: e.epc};
    end else if (t.valid) begin
      w = pc_write_t'{en: 1'b1, tid: t.tid, value: t.vector};
    end else if (c.valid) begin
      w = pc_write_t'{en: 1'b1, tid: c.tid, value: halt ? c.pc : c.pc + 32'd4};
    end else if (acc) begin
      w = pc_write_t'{en: 1'b1, tid: tid, value: pc + 32'd4};
    end
    return w;
  endfunction

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      mismatches++;
      $display("mismatch %s at %0t: expected %h, actual %h", name, $time, exp, act);
    end
  endtask

  task automatic check_entry(input string name, input fetch_entry_t exp,
                             input fetch_entry_t act);
    if (exp !== act) begin
      mismatches++;
      $display("mismatch %s at %0t: expected %h, actual %h", name, $time, exp, act);
    end
  endtask

  task automatic check_tid(input string name, input tid_t exp, input tid_t act);
    if (exp !== act) begin
      mismatches++;
      $display("mismatch %s at %0t: expected %0d, actual %0d", name, $time, exp, act);
    end
  endtask

  task automatic report_failure(input string what);
    failures++;
    $display("error at %0t: %s", $time, what);
  endtask

  // ----------------------------------------
  // icache model
  // ----------------------------------------
  // responses leave in order and each head waits 0 to 2 extra cycles
  always @(negedge clk_i) begin : cache_model
    icache_req_t head;
    icache_rsp_i.valid = 1'b0;
    icache_rsp_i.ready = rand_ready ? (($random(seed) & 3) != 0) : 1'b1;
    if (pend_q.size() > 0) begin
      if (rsp_delay < 0) begin
        rsp_delay = $unsigned($random(seed)) % 3;
      end
      if (rsp_delay == 0) begin
        head               = pend_q.pop_front();
        icache_rsp_i.valid = 1'b1;
        icache_rsp_i.tid   = head.tid;
        icache_rsp_i.vaddr = head.vaddr;
        icache_rsp_i.data  = instr_of(head.vaddr);
        icache_rsp_i.fault = (head.vaddr == fault_addr);
        rsp_delay          = -1;
      end else begin
        rsp_delay--;
      end
    end
  end

  // ----------------------------------------
  // compare process
  // ----------------------------------------
  always @(posedge clk_i) begin : compare
    fetch_entry_t exp_e;
    fetch_entry_t act_e;
    pc_write_t    wr;
    addr_t        req_pc;
    logic         acc;
    if (!rst_ni) begin
      for (int t = 0; t < `FETCH_NUM_THREADS; t++) begin
        model_pc[t] = boot_addr_i[t];
      end
    end else begin
      act_e = fetch_entry_o;
      acc   = icache_req_o.req && icache_rsp_i.ready;
      if (fetch_entry_valid_o && fetch_entry_ready_i) begin
        if (exp_q.size() == 0) begin
          report_failure($sformatf("entry at pc %h reached decode unexpectedly", act_e.pc));
        end else begin
          exp_e = exp_q.pop_front();
          check_tid("entry tid", exp_e.tid, act_e.tid);
          check_entry("entry", exp_e, act_e);
        end
        if (act_e.fault) begin
          fault_seen = 1'b1;
        end
        got_q.push_back(act_e);
      end
      if (acc) begin
        req_pc = model_pc[icache_req_o.tid];
        check_addr("request pc", req_pc, icache_req_o.vaddr);
        if (halt_i) begin
          report_failure("request accepted while halt_i was high");
        end
        if (rr_check && rr_started) begin
          check_tid("rotation", last_tid + tid_t'(1), icache_req_o.tid);
        end
        rr_started = rr_check;
        last_tid   = icache_req_o.tid;
        exp_e = '{tid: icache_req_o.tid, pc: req_pc, instr: instr_of(req_pc),
                  fault: (req_pc == fault_addr)};
        exp_q.push_back(exp_e);
        pend_q.push_back(icache_req_o);
      end
      if (!rr_check) begin
        rr_started = 1'b0;
      end
      wr = next_pc(branch_i, eret_i, trap_i, commit_i, halt_i, acc,
                   icache_req_o.tid, model_pc[icache_req_o.tid]);
      if (wr.en) begin
        model_pc[wr.tid] = wr.value;
      end
      // flush drops everything accepted up to and including this edge
      if (flush_i) begin
        exp_q.delete();
      end
    end
  end

  // first entry of a thread at or after history index start
  task automatic wait_first(input string name, input int start, input tid_t tid,
                            input addr_t exp_pc);
    int   waited;
    logic found;
    waited = 0;
    found  = 1'b0;
    while (!found && waited < 300) begin
      for (int i = start; i < got_q.size(); i++) begin
        if (!found && got_q[i].tid == tid) begin
          found = 1'b1;
          check_addr(name, exp_pc, got_q[i].pc);
        end
      end
      if (!found) begin
        @(negedge clk_i);
        waited++;
      end
    end
    if (!found) begin
      report_failure($sformatf("timeout waiting for a thread %0d entry (%s)", tid, name));
    end
  endtask

  task automatic wait_drain(input string name);
    int waited;
    waited = 0;
    while ((exp_q.size() != 0 || fetch_entry_valid_o) && waited < 200) begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_q.size() != 0 || fetch_entry_valid_o) begin
      report_failure($sformatf("timeout waiting for the queue to drain (%s)", name));
    end
  endtask

  // redirect with flush for one cycle and wait for the thread's next entry
  task automatic redirect_flush(input string name, input branch_resolve_t b,
                                input eret_req_t e, input trap_req_t t,
                                input commit_req_t c, input logic h,
                                input tid_t tid, input addr_t exp_pc);
    int start;
    branch_i = b;
    eret_i   = e;
    trap_i   = t;
    commit_i = c;
    halt_i   = h;
    flush_i  = 1'b1;
    @(negedge clk_i);
    branch_i = '0;
    eret_i   = '0;
    trap_i   = '0;
    commit_i = '0;
    halt_i   = 1'b0;
    flush_i  = 1'b0;
    start    = got_q.size();
    wait_first(name, start, tid, exp_pc);
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin : stimulus
    addr_t hold_pc [`FETCH_NUM_THREADS];
    int    start;
    rst_ni              = 1'b0;
    flush_i             = 1'b0;
    halt_i              = 1'b0;
    branch_i            = '0;
    eret_i              = '0;
    trap_i              = '0;
    commit_i            = '0;
    fetch_entry_ready_i = 1'b1;
    boot_addr_i[0]      = 32'h0000_1000;
    boot_addr_i[1]      = 32'h0000_2000;
    boot_addr_i[2]      = 32'h0000_3000;
    boot_addr_i[3]      = 32'h0000_4000;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;

    // boot, then sequential fetch under random cache stalls
    for (int t = 0; t < `FETCH_NUM_THREADS; t++) begin
      wait_first("boot pc", 0, tid_t'(t), boot_addr_i[t]);
    end
    repeat (40) @(negedge clk_i);

    // with the cache always ready the tids must rotate
    rand_ready <= 1'b0;
    repeat (4) @(negedge clk_i);
    rr_check = 1'b1;
    repeat (30) @(negedge clk_i);
    rr_check   = 1'b0;
    rand_ready <= 1'b1;

    redirect_flush("mispredict",
      branch_resolve_t'{valid: 1'b1, mispredict: 1'b1, tid: 2'd1, target: 32'h5000},
      '0, '0, '0, 1'b0, 2'd1, 32'h5000);
    redirect_flush("eret", '0, eret_req_t'{valid: 1'b1, tid: 2'd2, epc: 32'h6000},
      '0, '0, 1'b0, 2'd2, 32'h6000);
    redirect_flush("trap", '0, '0, trap_req_t'{valid: 1'b1, tid: 2'd3, vector: 32'h7000},
      '0, 1'b0, 2'd3, 32'h7000);
    redirect_flush("commit", '0, '0, '0,
      commit_req_t'{valid: 1'b1, tid: 2'd0, pc: 32'h8000}, 1'b0, 2'd0, 32'h8004);
    redirect_flush("commit under halt", '0, '0, '0,
      commit_req_t'{valid: 1'b1, tid: 2'd1, pc: 32'h9000}, 1'b1, 2'd1, 32'h9000);
    // eret beats trap and a branch without mispredict does nothing
    redirect_flush("eret over trap",
      branch_resolve_t'{valid: 1'b1, mispredict: 1'b0, tid: 2'd2, target: 32'hc000},
      eret_req_t'{valid: 1'b1, tid: 2'd2, epc: 32'hb000},
      trap_req_t'{valid: 1'b1, tid: 2'd2, vector: 32'ha000},
      '0, 1'b0, 2'd2, 32'hb000);
    redirect_flush("mispredict over commit",
      branch_resolve_t'{valid: 1'b1, mispredict: 1'b1, tid: 2'd3, target: 32'hd000},
      '0, '0, commit_req_t'{valid: 1'b1, tid: 2'd3, pc: 32'he000}, 1'b0, 2'd3, 32'hd000);

    // decode back-pressure until the credits are gone
    rand_ready          <= 1'b0;
    fetch_entry_ready_i = 1'b0;
    repeat (20) @(negedge clk_i);
    if (icache_req_o.req) begin
      report_failure("request still high with every credit in use");
    end
    if (!fetch_entry_valid_o) begin
      report_failure("no entry held at the queue head under back-pressure");
    end
    fetch_entry_ready_i = 1'b1;
    rand_ready          <= 1'b1;

    // halt, then resume at the same pcs
    halt_i = 1'b1;
    wait_drain("halt");
    repeat (5) @(negedge clk_i);
    for (int t = 0; t < `FETCH_NUM_THREADS; t++) begin
      hold_pc[t] = model_pc[t];
    end
    start  = got_q.size();
    halt_i = 1'b0;
    for (int t = 0; t < `FETCH_NUM_THREADS; t++) begin
      wait_first("resume after halt", start, tid_t'(t), hold_pc[t]);
    end
    repeat (20) @(negedge clk_i);

    halt_i = 1'b1;
    wait_drain("end of run");
    if (got_q.size() < 40) begin
      report_failure($sformatf("only %0d entries reached decode", got_q.size()));
    end
    if (!fault_seen) begin
      report_failure("fault flag never reached decode");
    end
    $display("checks done: %0d mismatches, %0d other errors, %0d entries",
             mismatches, failures, got_q.size());
    if (mismatches == 0 && failures == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+logic
logic/fetch_types_pkg.sv
logic/redirect_pkg.sv
logic/thread_context.sv
logic/thread_sched.sv
logic/npc_select.sv
logic/fetch_queue.sv
logic/fetch_frontend.sv
bench/fetch_frontend_tb.sv

//--- logic/fetch_frontend.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_frontend (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  fetch_types_pkg::addr_t [`FETCH_NUM_THREADS-1:0] boot_addr_i,
  input  logic                                            flush_i,
  input  logic                                            halt_i,
  input  redirect_pkg::branch_resolve_t                   branch_i,
  input  redirect_pkg::eret_req_t                         eret_i,
  input  redirect_pkg::trap_req_t                         trap_i,
  input  redirect_pkg::commit_req_t                       commit_i,
  output fetch_types_pkg::icache_req_t                    icache_req_o,
  input  fetch_types_pkg::icache_rsp_t                    icache_rsp_i,
  output fetch_types_pkg::fetch_entry_t                   fetch_entry_o,
  output logic                                            fetch_entry_valid_o,
  input  logic                                            fetch_entry_ready_i
);

  import fetch_types_pkg::*;
  import redirect_pkg::*;

  addr_t                                   cur_pc;
  tid_t                                    cur_tid;
  logic                                    req;
  logic                                    accept;
  logic                                    has_credit;
  logic                                    boot_load;
  pc_write_t                               pc_write;
  thread_status_e [`FETCH_NUM_THREADS-1:0] status;
  logic                                    status_we;
  tid_t                                    status_tid;
  thread_status_e                          status_val;

  // ----------------------------------------
  // icache request
  // ----------------------------------------
  assign accept             = req && icache_rsp_i.ready;
  assign icache_req_o.req   = req;
  assign icache_req_o.tid   = cur_tid;
  assign icache_req_o.vaddr = cur_pc;

  thread_context i_thread_context (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .boot_addr_i  (boot_addr_i),
    .pc_write_i   (pc_write),
    .status_we_i  (status_we),
    .status_tid_i (status_tid),
    .status_val_i (status_val),
    .rd_tid_i     (cur_tid),
    .pc_o         (cur_pc),
    .status_o     (status),
    .boot_load_o  (boot_load)
  );

  thread_sched i_thread_sched (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .has_credit_i   (has_credit),
    .halt_i         (halt_i),
    .flush_i        (flush_i),
    .boot_load_i    (boot_load),
    .status_i       (status),
    .icache_ready_i (icache_rsp_i.ready),
    .cur_tid_o      (cur_tid),
    .req_o          (req),
    .status_we_o    (status_we),
    .status_tid_o   (status_tid),
    .status_val_o   (status_val)
  );

  npc_select i_npc_select (
    .branch_i   (branch_i),
    .eret_i     (eret_i),
    .trap_i     (trap_i),
    .commit_i   (commit_i),
    .halt_i     (halt_i),
    .accept_i   (accept),
    .cur_tid_i  (cur_tid),
    .cur_pc_i   (cur_pc),
    .pc_write_o (pc_write)
  );

  fetch_queue i_fetch_queue (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .flush_i             (flush_i),
    .accept_i            (accept),
    .rsp_i               (icache_rsp_i),
    .has_credit_o        (has_credit),
    .fetch_entry_o       (fetch_entry_o),
    .fetch_entry_valid_o (fetch_entry_valid_o),
    .fetch_entry_ready_i (fetch_entry_ready_i)
  );

endmodule

//--- logic/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// ----------------------------------------
// frontend sizing
// ----------------------------------------

// virtual address width
`define FETCH_VLEN 32

// hardware threads and the width of a thread id
`define FETCH_NUM_THREADS 4
`define FETCH_TID_W 2

// fetch queue entries, also the number of credits
`define FETCH_QUEUE_DEPTH 4

// one 32-bit instruction per request
`define FETCH_INSTR_BYTES 4

`endif

//--- logic/fetch_queue.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module fetch_queue (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  input  logic                          accept_i,
  input  fetch_types_pkg::icache_rsp_t  rsp_i,
  output logic                          has_credit_o,
  output fetch_types_pkg::fetch_entry_t fetch_entry_o,
  output logic                          fetch_entry_valid_o,
  input  logic                          fetch_entry_ready_i
);

  import fetch_types_pkg::*;

  localparam int unsigned depth = `FETCH_QUEUE_DEPTH;
  localparam int unsigned ptr_w = $clog2(depth);
  localparam int unsigned cnt_w = $clog2(depth + 1);

  typedef logic [ptr_w-1:0] ptr_t;
  typedef logic [cnt_w-1:0] cnt_t;
  typedef logic [cnt_w:0]   sum_t;

  fetch_entry_t mem_q [depth];
  ptr_t         wr_ptr_q;
  ptr_t         rd_ptr_q;
  cnt_t         count_q;
  cnt_t         out_q;
  cnt_t         drop_q;
  cnt_t         out_next;
  logic         push;
  logic         pop;
  logic         dropping;

  // responses to requests issued before a flush are thrown away
  assign dropping = rsp_i.valid && (drop_q != '0);
  assign push     = rsp_i.valid && (drop_q == '0) && !flush_i;
  assign pop      = fetch_entry_valid_o && fetch_entry_ready_i;

  // requests in flight after this edge
  assign out_next = out_q + cnt_t'(accept_i) - cnt_t'(rsp_i.valid);

  // stored plus in-flight never exceeds the queue size
  assign has_credit_o = (sum_t'(count_q) + sum_t'(out_q)) < sum_t'(depth);

  // ----------------------------------------
  // storage
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= '{
        tid:   rsp_i.tid,
        pc:    rsp_i.vaddr,
        instr: rsp_i.data,
        fault: rsp_i.fault
      };
    end
  end

  // ----------------------------------------
  // pointers and counters
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      out_q    <= '0;
      drop_q   <= '0;
    end else begin
      out_q <= out_next;
      if (flush_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
        drop_q   <= out_next;
      end else begin
        if (push) begin
          wr_ptr_q <= wr_ptr_q + ptr_t'(1);
        end
        if (pop) begin
          rd_ptr_q <= rd_ptr_q + ptr_t'(1);
        end
        count_q <= count_q + cnt_t'(push) - cnt_t'(pop);
        if (dropping) begin
          drop_q <= drop_q - cnt_t'(1);
        end
      end
    end
  end

  assign fetch_entry_valid_o = (count_q != '0);
  assign fetch_entry_o       = mem_q[rd_ptr_q];

  // credits given to the scheduler must keep the queue from filling past depth
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push |-> count_q < cnt_t'(depth))
    else $error("fetch queue overflow");

  // the cache only answers requests it accepted earlier
  a_rsp_expected: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_i.valid |-> out_q != '0)
    else $error("icache response without an outstanding request");

endmodule

//--- logic/fetch_types_pkg.sv
`include "fetch_macros.svh"

package fetch_types_pkg;

  // ----------------------------------------
  // basic widths
  // ----------------------------------------
  typedef logic [`FETCH_VLEN-1:0] addr_t;
  typedef logic [31:0] instr_t;
  typedef logic [`FETCH_TID_W-1:0] tid_t;

  // a thread leaves READY only while it waits on an icache miss
  typedef enum logic {
    READY,
    STALLED_ICACHE
  } thread_status_e;

  // ----------------------------------------
  // icache link
  // ----------------------------------------
  typedef struct packed {
    logic  req;
    tid_t  tid;
    addr_t vaddr;
  } icache_req_t;

  // ready is a level, valid strobes once per returned request
  typedef struct packed {
    logic   ready;
    logic   valid;
    logic   fault;
    tid_t   tid;
    addr_t  vaddr;
    instr_t data;
  } icache_rsp_t;

  // ----------------------------------------
  // towards decode
  // ----------------------------------------
  typedef struct packed {
    tid_t   tid;
    addr_t  pc;
    instr_t instr;
    logic   fault;
  } fetch_entry_t;

endpackage

//--- logic/npc_select.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module npc_select (
  input  redirect_pkg::branch_resolve_t branch_i,
  input  redirect_pkg::eret_req_t       eret_i,
  input  redirect_pkg::trap_req_t       trap_i,
  input  redirect_pkg::commit_req_t     commit_i,
  input  logic                          halt_i,
  input  logic                          accept_i,
  input  fetch_types_pkg::tid_t         cur_tid_i,
  input  fetch_types_pkg::addr_t        cur_pc_i,
  output redirect_pkg::pc_write_t       pc_write_o
);

  import fetch_types_pkg::*;

  localparam addr_t pc_step = addr_t'(`FETCH_INSTR_BYTES);

  // ----------------------------------------
  // one pc write per cycle
  // ----------------------------------------
  // back-end redirects beat the sequential advance, and any of them
  // swallows the advance of an accepted request in the same cycle
  always_comb begin
    pc_write_o.en    = 1'b0;
    pc_write_o.tid   = cur_tid_i;
    pc_write_o.value = cur_pc_i + pc_step;
    if (branch_i.valid && branch_i.mispredict) begin
      pc_write_o.en    = 1'b1;
      pc_write_o.tid   = branch_i.tid;
      pc_write_o.value = branch_i.target;
    end else if (eret_i.valid) begin
      pc_write_o.en    = 1'b1;
      pc_write_o.tid   = eret_i.tid;
      pc_write_o.value = eret_i.epc;
    end else if (trap_i.valid) begin
      pc_write_o.en    = 1'b1;
      pc_write_o.tid   = trap_i.tid;
      pc_write_o.value = trap_i.vector;
    end else if (commit_i.valid) begin
      // halted core restarts on the committed instruction itself
      pc_write_o.en    = 1'b1;
      pc_write_o.tid   = commit_i.tid;
      pc_write_o.value = commit_i.pc + (halt_i ? addr_t'(0) : pc_step);
    end else if (accept_i) begin
      pc_write_o.en = 1'b1;
    end
  end

endmodule

//--- logic/redirect_pkg.sv
package redirect_pkg;

  import fetch_types_pkg::*;

  // ----------------------------------------
  // back-end control flow requests
  // ----------------------------------------

  // resolved branch from execute, only a mispredict redirects
  typedef struct packed {
    logic  valid;
    logic  mispredict;
    tid_t  tid;
    addr_t target;
  } branch_resolve_t;

  // return from exception
  typedef struct packed {
    logic  valid;
    tid_t  tid;
    addr_t epc;
  } eret_req_t;

  // exception or interrupt entry
  typedef struct packed {
    logic  valid;
    tid_t  tid;
    addr_t vector;
  } trap_req_t;

  // restart after the committed pc (fence, csr side effects)
  typedef struct packed {
    logic  valid;
    tid_t  tid;
    addr_t pc;
  } commit_req_t;

  // single pc write port into the thread context
  typedef struct packed {
    logic  en;
    tid_t  tid;
    addr_t value;
  } pc_write_t;

endpackage

//--- logic/thread_context.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module thread_context (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  fetch_types_pkg::addr_t [`FETCH_NUM_THREADS-1:0]        boot_addr_i,
  input  redirect_pkg::pc_write_t                                pc_write_i,
  input  logic                                                   status_we_i,
  input  fetch_types_pkg::tid_t                                  status_tid_i,
  input  fetch_types_pkg::thread_status_e                        status_val_i,
  input  fetch_types_pkg::tid_t                                  rd_tid_i,
  output fetch_types_pkg::addr_t                                 pc_o,
  output fetch_types_pkg::thread_status_e [`FETCH_NUM_THREADS-1:0] status_o,
  output logic                                                   boot_load_o
);

  import fetch_types_pkg::*;

  addr_t          [`FETCH_NUM_THREADS-1:0] pc_q;
  thread_status_e [`FETCH_NUM_THREADS-1:0] status_q;
  logic                                    boot_load_q;
  logic                                    status_clash;

  // scheduler update loses against a pc write to the same thread
  assign status_clash = pc_write_i.en && (pc_write_i.tid == status_tid_i);

  // ----------------------------------------
  // pc registers
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (boot_load_q) begin
      pc_q <= boot_addr_i;
    end else if (pc_write_i.en) begin
      pc_q[pc_write_i.tid] <= pc_write_i.value;
    end
  end

  // ----------------------------------------
  // status and boot flag
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      boot_load_q <= 1'b1;
      for (int i = 0; i < `FETCH_NUM_THREADS; i++) begin
        status_q[i] <= READY;
      end
    end else begin
      boot_load_q <= 1'b0;
      if (!boot_load_q) begin
        // any redirect or advance releases the thread
        if (pc_write_i.en) begin
          status_q[pc_write_i.tid] <= READY;
        end
        if (status_we_i && !status_clash) begin
          status_q[status_tid_i] <= status_val_i;
        end
      end
    end
  end

  assign pc_o        = pc_q[rd_tid_i];
  assign status_o    = status_q;
  assign boot_load_o = boot_load_q;

  // whatever source wrote it, the stored pc stays on an instruction boundary
  a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pc_write_i.en && !boot_load_q
    |=> (pc_q[$past(pc_write_i.tid)] % `FETCH_INSTR_BYTES) == 0)
    else $error("misaligned pc stored for a thread");

endmodule

//--- logic/thread_sched.sv
`timescale 1ns/1ps
`include "fetch_macros.svh"

module thread_sched (
  input  logic                                                     clk_i,
  input  logic                                                     rst_ni,
  input  logic                                                     has_credit_i,
  input  logic                                                     halt_i,
  input  logic                                                     flush_i,
  input  logic                                                     boot_load_i,
  input  fetch_types_pkg::thread_status_e [`FETCH_NUM_THREADS-1:0] status_i,
  input  logic                                                     icache_ready_i,
  output fetch_types_pkg::tid_t                                    cur_tid_o,
  output logic                                                     req_o,
  output logic                                                     status_we_o,
  output fetch_types_pkg::tid_t                                    status_tid_o,
  output fetch_types_pkg::thread_status_e                          status_val_o
);

  import fetch_types_pkg::*;

  tid_t cur_tid_q;
  tid_t cur_tid_d;
  tid_t stalled_tid_q;
  tid_t stalled_tid_d;
  logic pending_q;
  logic pending_d;
  logic advance;

  // no fetch while the pcs load after reset
  assign advance   = has_credit_i && !halt_i && !boot_load_i;
  assign req_o     = advance && (status_i[cur_tid_q] == READY);
  assign cur_tid_o = cur_tid_q;

  // ----------------------------------------
  // round robin from current + 1
  // ----------------------------------------
  always_comb begin : pick_next
    tid_t cand;
    cur_tid_d = cur_tid_q;
    cand      = cur_tid_q;
    // walk downwards so the nearest ready thread is the last one kept
    if (advance) begin
      for (int i = `FETCH_NUM_THREADS - 1; i >= 1; i--) begin
        cand = cur_tid_q + tid_t'(i);
        if (status_i[cand] == READY) begin
          cur_tid_d = cand;
        end
      end
    end
  end

  // ----------------------------------------
  // single pending icache miss
  // ----------------------------------------
  always_comb begin : stall_track
    status_we_o   = 1'b0;
    status_tid_o  = cur_tid_q;
    status_val_o  = READY;
    pending_d     = pending_q;
    stalled_tid_d = stalled_tid_q;
    if (flush_i) begin
      // flush drops the tracking and lets the waiting thread go
      pending_d = 1'b0;
      if (pending_q) begin
        status_we_o  = 1'b1;
        status_tid_o = stalled_tid_q;
      end
    end else if (pending_q) begin
      if (icache_ready_i) begin
        status_we_o  = 1'b1;
        status_tid_o = stalled_tid_q;
        pending_d    = 1'b0;
      end
    end else if (req_o && !icache_ready_i) begin
      status_we_o   = 1'b1;
      status_val_o  = STALLED_ICACHE;
      pending_d     = 1'b1;
      stalled_tid_d = cur_tid_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cur_tid_q     <= '0;
      stalled_tid_q <= '0;
      pending_q     <= 1'b0;
    end else begin
      cur_tid_q     <= cur_tid_d;
      stalled_tid_q <= stalled_tid_d;
      pending_q     <= pending_d;
    end
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the fetch frontend testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module fetch_frontend_tb \
  && ./obj_dir/Vfetch_frontend_tb 2>&1 | tee sim.log \
  || { echo "build or run failed"; exit 1; }

grep -q "^TEST OK$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
